//--- rtl/dec_pkg.sv
//************************************************
// decode package
// instruction word views, opcodes, ALU op codes
// and instruction buffer sizing
//************************************************
`default_nettype none

package dec_pkg;

   localparam int XLEN       = 32;               // data and instruction width
   localparam int REG_ADDR_W = 5;                // x0..x31
   localparam int IB_DEPTH   = 2;                // instruction buffer entries

   //************************************************
   // major opcodes accepted at decode
   //************************************************
   localparam logic [6:0] OPC_OP     = 7'b0110011; // reg-reg alu
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // reg-imm alu
   localparam logic [6:0] OPC_LUI    = 7'b0110111;

   localparam logic [6:0] F7_BASE = 7'b0000000;  // add, srl and friends
   localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra

   //************************************************
   // alu op codes
   //************************************************
   localparam int ALU_OP_W = 4;

   localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
   localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
   localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
   localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
   localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
   localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
   localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
   localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
   localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
   localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;
   localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd10; // imm passes straight through

   // one instruction word, three ways to look at it
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;                                       // register-register
      struct packed {
         logic [11:0] imm12;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;                                       // register-immediate
      struct packed {
         logic [19:0] imm20;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u;                                       // upper immediate
   } instr_u;

endpackage

`default_nettype wire

//--- rtl/dec_ib_ctl.sv
//************************************************
// instruction buffer
// circular FIFO of instruction and pc between
// fetch and decode
//************************************************
`timescale 1ns/1ps
`default_nettype none

module dec_ib_ctl #(
   parameter int DEPTH = dec_pkg::IB_DEPTH       // 2 or more
) (
   input  logic                     clk,
   input  logic                     rst_n,

   input  logic                     fetch_valid,
   input  logic [dec_pkg::XLEN-1:0] fetch_instr,
   input  logic [dec_pkg::XLEN-1:0] fetch_pc,
   output logic                     fetch_ready,

   output logic                     head_valid,  // entry waiting at decode
   output logic [dec_pkg::XLEN-1:0] head_instr,
   output logic [dec_pkg::XLEN-1:0] head_pc,
   input  logic                     head_pop     // decode retires the head
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [dec_pkg::XLEN-1:0] instr_mem [DEPTH];  // payload only
   logic [dec_pkg::XLEN-1:0] pc_mem    [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;                      // entries held

   logic push;
   logic pop;

   // wrap at DEPTH, depth need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign fetch_ready = (count != CNT_W'(DEPTH)); // registered occupancy only
   assign head_valid  = (count != '0);
   assign push        = fetch_valid & fetch_ready;
   assign pop         = head_pop & head_valid;

   assign head_instr = instr_mem[rd_ptr];
   assign head_pc    = pc_mem[rd_ptr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= ptr_inc(wr_ptr);
         if (pop)  rd_ptr <= ptr_inc(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;      // fill
            2'b01:   count <= count - 1'b1;      // drain
            default: count <= count;             // both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         instr_mem[wr_ptr] <= fetch_instr;
         pc_mem[wr_ptr]    <= fetch_pc;
      end
   end

endmodule

`default_nettype wire

//--- rtl/dec_decode_ctl.sv
//************************************************
// decode control
// field extraction, legality, immediate and alu op
// generation, issue handshake
//************************************************
`timescale 1ns/1ps
`default_nettype none

module dec_decode_ctl (
   input  logic                           head_valid,
   input  logic [dec_pkg::XLEN-1:0]       head_instr,
   input  logic [dec_pkg::XLEN-1:0]       head_pc,
   output logic                           head_pop,

   output logic [dec_pkg::REG_ADDR_W-1:0] rs1_addr,  // to scoreboard and arf
   output logic [dec_pkg::REG_ADDR_W-1:0] rs2_addr,
   output logic [dec_pkg::REG_ADDR_W-1:0] rd_addr,
   output logic                           rs1_use,
   output logic                           rs2_use,
   output logic                           rd_use,
   output logic                           issue_fire,
   input  logic                           hazard,
   input  logic [dec_pkg::XLEN-1:0]       rs1_data,
   input  logic [dec_pkg::XLEN-1:0]       rs2_data,

   output logic                           issue_valid,
   input  logic                           issue_ready,
   output logic [dec_pkg::ALU_OP_W-1:0]   issue_op,
   output logic [dec_pkg::XLEN-1:0]       issue_rs1_data,
   output logic [dec_pkg::XLEN-1:0]       issue_rs2_data,
   output logic [dec_pkg::XLEN-1:0]       issue_imm,
   output logic [dec_pkg::XLEN-1:0]       issue_pc,
   output logic [dec_pkg::REG_ADDR_W-1:0] issue_rd,
   output logic                           issue_illegal
);

   dec_pkg::instr_u instr;

   logic                         legal;
   logic                         is_r;           // reg-reg group
   logic                         is_i;           // reg-imm group
   logic                         is_u;           // lui
   logic [dec_pkg::ALU_OP_W-1:0] op;
   logic [6:0]                   f7;             // funct7, or imm[11:5] for shifts

   assign instr = head_instr;
   assign is_r  = (instr.r.opcode == dec_pkg::OPC_OP);
   assign is_i  = (instr.i.opcode == dec_pkg::OPC_OP_IMM);
   assign is_u  = (instr.u.opcode == dec_pkg::OPC_LUI);
   assign f7    = instr.r.funct7;                // same bits in both groups

   //************************************************
   // legality and alu op
   //************************************************
   always_comb begin
      legal = 1'b0;
      op    = dec_pkg::ALU_ADD;
      if (is_r || is_i) begin
         case (instr.r.funct3)
            3'b000: begin
               op    = (is_r && f7 == dec_pkg::F7_ALT) ? dec_pkg::ALU_SUB : dec_pkg::ALU_ADD;
               legal = is_i || f7 == dec_pkg::F7_BASE || f7 == dec_pkg::F7_ALT;
            end
            3'b001: begin
               op    = dec_pkg::ALU_SLL;
               legal = (f7 == dec_pkg::F7_BASE); // shamt upper bits too
            end
            3'b010: begin
               op    = dec_pkg::ALU_SLT;
               legal = is_i || f7 == dec_pkg::F7_BASE;
            end
            3'b011: begin
               op    = dec_pkg::ALU_SLTU;
               legal = is_i || f7 == dec_pkg::F7_BASE;
            end
            3'b100: begin
               op    = dec_pkg::ALU_XOR;
               legal = is_i || f7 == dec_pkg::F7_BASE;
            end
            3'b101: begin
               op    = (f7 == dec_pkg::F7_ALT) ? dec_pkg::ALU_SRA : dec_pkg::ALU_SRL;
               legal = (f7 == dec_pkg::F7_BASE) || (f7 == dec_pkg::F7_ALT);
            end
            3'b110: begin
               op    = dec_pkg::ALU_OR;
               legal = is_i || f7 == dec_pkg::F7_BASE;
            end
            default: begin
               op    = dec_pkg::ALU_AND;
               legal = is_i || f7 == dec_pkg::F7_BASE;
            end
         endcase
      end else if (is_u) begin
         op    = dec_pkg::ALU_LUI;
         legal = 1'b1;
      end
   end

   //************************************************
   // immediate
   //************************************************
   always_comb begin
      if (is_i)
         issue_imm = {{(dec_pkg::XLEN - 12){instr.i.imm12[11]}}, instr.i.imm12}; // sext
      else if (is_u)
         issue_imm = {instr.u.imm20, 12'b0};
      else
         issue_imm = '0;                         // r type and illegal
   end

   // operand use, illegal words touch no register
   assign rs1_use = legal & (is_r | is_i);
   assign rs2_use = legal & is_r;
   assign rd_use  = legal;
   assign rs1_addr = instr.r.rs1;
   assign rs2_addr = instr.r.rs2;
   assign rd_addr  = instr.r.rd;

   assign issue_valid = head_valid & ~hazard;
   assign issue_fire  = issue_valid & issue_ready;
   assign head_pop    = issue_fire;

   assign issue_op       = op;
   assign issue_rs1_data = rs1_use ? rs1_data : '0;
   assign issue_rs2_data = rs2_use ? rs2_data : '0; // r type only
   assign issue_pc       = head_pc;
   assign issue_rd       = rd_use ? rd_addr : '0;   // x0 dest already zero
   assign issue_illegal  = ~legal;

endmodule

`default_nettype wire

//--- rtl/dec_scoreboard.sv
//************************************************
// dependency scoreboard
// pending-write bitmap and decode hazard detect
//************************************************
`timescale 1ns/1ps
`default_nettype none

module dec_scoreboard (
   input  logic                           clk,
   input  logic                           rst_n,

   input  logic [dec_pkg::REG_ADDR_W-1:0] rs1_addr,
   input  logic [dec_pkg::REG_ADDR_W-1:0] rs2_addr,
   input  logic [dec_pkg::REG_ADDR_W-1:0] rd_addr,
   input  logic                           rs1_use,
   input  logic                           rs2_use,
   input  logic                           rd_use,
   input  logic                           issue_fire,  // rd goes pending

   input  logic                           wb_valid,    // rd result is back
   input  logic [dec_pkg::REG_ADDR_W-1:0] wb_rd,

   output logic                           hazard
);

   localparam int NREG = 2 ** dec_pkg::REG_ADDR_W;

   logic [NREG-1:0] pending;                     // bit 0 stays clear
   logic [NREG-1:0] wb_clr;
   logic [NREG-1:0] issue_set;
   logic [NREG-1:0] pend_eff;                    // minus this cycle's writeback

   assign wb_clr    = wb_valid ? (NREG'(1) << wb_rd) : '0;
   assign issue_set = (issue_fire && rd_use && rd_addr != '0) ? (NREG'(1) << rd_addr) : '0;
   assign pend_eff  = pending & ~wb_clr;

   // raw on sources, waw on dest
   assign hazard = (rs1_use & pend_eff[rs1_addr]) |
                   (rs2_use & pend_eff[rs2_addr]) |
                   (rd_use  & pend_eff[rd_addr]);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         pending <= '0;
      else
         pending <= pend_eff | issue_set;        // new issue wins over wb
   end

endmodule

`default_nettype wire

//--- rtl/dec_gpr_ctl.sv
//************************************************
// architectural register file
// x1..x31, two read ports, one write port with
// write-through to the readers
//************************************************
`timescale 1ns/1ps
`default_nettype none

module dec_gpr_ctl (
   input  logic                           clk,
   input  logic                           rst_n,

   input  logic [dec_pkg::REG_ADDR_W-1:0] rd_addr0,
   input  logic [dec_pkg::REG_ADDR_W-1:0] rd_addr1,
   output logic [dec_pkg::XLEN-1:0]       rd_data0,
   output logic [dec_pkg::XLEN-1:0]       rd_data1,

   input  logic                           wr_en,
   input  logic [dec_pkg::REG_ADDR_W-1:0] wr_addr,
   input  logic [dec_pkg::XLEN-1:0]       wr_data
);

   localparam int NREG = 2 ** dec_pkg::REG_ADDR_W;

   logic [dec_pkg::XLEN-1:0] gpr [1:NREG-1];     // no storage for x0

   // one read port, x0 hardwired, same-cycle write bypassed
   function automatic logic [dec_pkg::XLEN-1:0] rd_port(
      input logic [dec_pkg::REG_ADDR_W-1:0] addr
   );
      if (addr == '0)
         return '0;
      if (wr_en && wr_addr == addr)
         return wr_data;                         // write-through
      return gpr[addr];
   endfunction

   always_comb rd_data0 = rd_port(rd_addr0);
   always_comb rd_data1 = rd_port(rd_addr1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < NREG; i++)
            gpr[i] <= '0;                        // arch state reads zero
      end else if (wr_en && wr_addr != '0) begin
         gpr[wr_addr] <= wr_data;
      end
   end

endmodule

`default_nettype wire

//--- rtl/dec.sv
//************************************************
// decode unit top
// instruction buffer, decoder, scoreboard and
// register file
//************************************************
`timescale 1ns/1ps
`default_nettype none

module dec (
   input  logic                           clk,
   input  logic                           rst_n,

   input  logic                           fetch_valid,
   input  logic [dec_pkg::XLEN-1:0]       fetch_instr,
   input  logic [dec_pkg::XLEN-1:0]       fetch_pc,
   output logic                           fetch_ready,

   output logic                           issue_valid,
   input  logic                           issue_ready,
   output logic [dec_pkg::ALU_OP_W-1:0]   issue_op,
   output logic [dec_pkg::XLEN-1:0]       issue_rs1_data,
   output logic [dec_pkg::XLEN-1:0]       issue_rs2_data,
   output logic [dec_pkg::XLEN-1:0]       issue_imm,
   output logic [dec_pkg::XLEN-1:0]       issue_pc,
   output logic [dec_pkg::REG_ADDR_W-1:0] issue_rd,
   output logic                           issue_illegal,

   input  logic                           wb_valid,  // always accepted
   input  logic [dec_pkg::REG_ADDR_W-1:0] wb_rd,
   input  logic [dec_pkg::XLEN-1:0]       wb_data
);

   logic                           head_valid;   // buffer head to decode
   logic [dec_pkg::XLEN-1:0]       head_instr;
   logic [dec_pkg::XLEN-1:0]       head_pc;
   logic                           head_pop;

   logic [dec_pkg::REG_ADDR_W-1:0] rs1_addr;
   logic [dec_pkg::REG_ADDR_W-1:0] rs2_addr;
   logic [dec_pkg::REG_ADDR_W-1:0] rd_addr;
   logic                           rs1_use;
   logic                           rs2_use;
   logic                           rd_use;
   logic                           issue_fire;
   logic                           hazard;
   logic [dec_pkg::XLEN-1:0]       rs1_data;     // arf read data
   logic [dec_pkg::XLEN-1:0]       rs2_data;

   //************************************************
   // instances
   //************************************************
   dec_ib_ctl instbuff (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_valid (fetch_valid),
      .fetch_instr (fetch_instr),
      .fetch_pc    (fetch_pc),
      .fetch_ready (fetch_ready),
      .head_valid  (head_valid),
      .head_instr  (head_instr),
      .head_pc     (head_pc),
      .head_pop    (head_pop)
   );

   dec_decode_ctl decode (
      .head_valid     (head_valid),
      .head_instr     (head_instr),
      .head_pc        (head_pc),
      .head_pop       (head_pop),
      .rs1_addr       (rs1_addr),
      .rs2_addr       (rs2_addr),
      .rd_addr        (rd_addr),
      .rs1_use        (rs1_use),
      .rs2_use        (rs2_use),
      .rd_use         (rd_use),
      .issue_fire     (issue_fire),
      .hazard         (hazard),
      .rs1_data       (rs1_data),
      .rs2_data       (rs2_data),
      .issue_valid    (issue_valid),
      .issue_ready    (issue_ready),
      .issue_op       (issue_op),
      .issue_rs1_data (issue_rs1_data),
      .issue_rs2_data (issue_rs2_data),
      .issue_imm      (issue_imm),
      .issue_pc       (issue_pc),
      .issue_rd       (issue_rd),
      .issue_illegal  (issue_illegal)
   );

   dec_scoreboard scbd (
      .clk        (clk),
      .rst_n      (rst_n),
      .rs1_addr   (rs1_addr),
      .rs2_addr   (rs2_addr),
      .rd_addr    (rd_addr),
      .rs1_use    (rs1_use),
      .rs2_use    (rs2_use),
      .rd_use     (rd_use),
      .issue_fire (issue_fire),
      .wb_valid   (wb_valid),                    // clears pending
      .wb_rd      (wb_rd),
      .hazard     (hazard)
   );

   dec_gpr_ctl arf (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_addr0 (rs1_addr),
      .rd_addr1 (rs2_addr),
      .rd_data0 (rs1_data),
      .rd_data1 (rs2_data),
      .wr_en    (wb_valid),                      // same strobe as scbd
      .wr_addr  (wb_rd),
      .wr_data  (wb_data)
   );

endmodule

`default_nettype wire

//--- tb/dec_properties.sv
//************************************************
// decode unit handshake properties
// issue stability, reset and illegal-word rules
//************************************************
`timescale 1ns/1ps
`default_nettype none

module dec_properties (
   input logic                           clk,
   input logic                           rst_n,
   input logic                           fetch_ready,
   input logic                           issue_valid,
   input logic                           issue_ready,
   input logic [dec_pkg::ALU_OP_W-1:0]   issue_op,
   input logic [dec_pkg::XLEN-1:0]       issue_rs1_data,
   input logic [dec_pkg::XLEN-1:0]       issue_rs2_data,
   input logic [dec_pkg::XLEN-1:0]       issue_imm,
   input logic [dec_pkg::XLEN-1:0]       issue_pc,
   input logic [dec_pkg::REG_ADDR_W-1:0] issue_rd,
   input logic                           issue_illegal
);

   // stalled issue holds valid and its whole payload
   a_issue_stable: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid && !issue_ready |=> issue_valid &&
      $stable({issue_op, issue_rs1_data, issue_rs2_data, issue_imm, issue_pc,
               issue_rd, issue_illegal}))
      else $error("issue payload changed under back-pressure");

   a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !issue_valid)
      else $error("issue_valid high during reset");

   a_illegal_no_rd: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid && issue_illegal |-> issue_rd == '0)   // nothing to write back
      else $error("illegal instruction carries a destination");

   a_ready_after_reset: assert property (@(posedge clk) !rst_n |=> fetch_ready)
      else $error("fetch_ready low right after reset");

endmodule

`default_nettype wire

//--- tb/tb_dec.sv
//************************************************
// decode unit testbench
// directed tests against a register and queue model
//************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_dec;

   localparam int N_RAND        = 40;            // words per random burst
   localparam int TOTAL_INSTR   = 2 * N_RAND + 40;
   localparam int CYC_PER_INSTR = 50;            // covers stalls and back-pressure
   localparam int WATCHDOG_NS   = (10 + TOTAL_INSTR * CYC_PER_INSTR) * 4;

   logic        clk = 1'b0;
   logic        rst_n = 1'b0;
   logic        fetch_valid = 1'b0;
   logic [31:0] fetch_instr = '0;
   logic [31:0] fetch_pc = '0;
   logic        fetch_ready;
   logic        issue_ready = 1'b0;
   logic        issue_valid;
   logic [3:0]  issue_op;
   logic [31:0] issue_rs1_data;
   logic [31:0] issue_rs2_data;
   logic [31:0] issue_imm;
   logic [31:0] issue_pc;
   logic [4:0]  issue_rd;
   logic        issue_illegal;
   logic        wb_valid = 1'b0;
   logic [4:0]  wb_rd = '0;
   logic [31:0] wb_data = '0;

   logic [31:0] regs [32] = '{default: '0};      // architectural values
   logic [31:0] pend = '0;                       // issued, not written back
   logic [63:0] exp_q [$];                       // {pc, word} in fetch order
   logic [4:0]  wb_q [$];                        // issued destinations
   int          wb_idx = 0;                      // next wb_q entry to write back
   int          held = 0;                        // entries in the buffer
   logic [31:0] pc_next = 32'h8000_0000;
   logic        bp_on = 1'b0;                    // random issue_ready
   logic        wb_hold = 1'b0;                  // no automatic writebacks
   int          force_req = 0;
   int          force_ack = 0;
   logic [31:0] force_data = '0;

   always #2 clk = ~clk;

   dec i_dec (
      .clk (clk), .rst_n (rst_n),
      .fetch_valid (fetch_valid), .fetch_instr (fetch_instr), .fetch_pc (fetch_pc),
      .fetch_ready (fetch_ready),
      .issue_valid (issue_valid), .issue_ready (issue_ready), .issue_op (issue_op),
      .issue_rs1_data (issue_rs1_data), .issue_rs2_data (issue_rs2_data),
      .issue_imm (issue_imm), .issue_pc (issue_pc), .issue_rd (issue_rd),
      .issue_illegal (issue_illegal),
      .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data)
   );

   bind dec dec_properties i_props (
      .clk (clk), .rst_n (rst_n), .fetch_ready (fetch_ready),
      .issue_valid (issue_valid), .issue_ready (issue_ready), .issue_op (issue_op),
      .issue_rs1_data (issue_rs1_data), .issue_rs2_data (issue_rs2_data),
      .issue_imm (issue_imm), .issue_pc (issue_pc), .issue_rd (issue_rd),
      .issue_illegal (issue_illegal)
   );

   task automatic die(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         die($sformatf("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
   endtask

   //************************************************
   // stimulus builders and reference decoder
   //************************************************
   function automatic logic [31:0] mk_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
      dec_pkg::instr_u w;
      w.r.funct7 = f7;                           // imm[11:5] for the i group
      w.r.rs2    = rs2;
      w.r.rs1    = rs1;
      w.r.funct3 = f3;
      w.r.rd     = rd;
      w.r.opcode = opc;
      return w;
   endfunction

   function automatic logic [31:0] mk_u(input logic [19:0] imm, input logic [4:0] rd);
      dec_pkg::instr_u w;
      w.u.imm20  = imm;
      w.u.rd     = rd;
      w.u.opcode = dec_pkg::OPC_LUI;
      return w;
   endfunction

   function automatic logic [31:0] rand_word();
      logic [6:0] f7;
      logic [2:0] f3;
      f7 = ($urandom_range(0, 3) == 0) ? 7'h20 : 7'h00; // mostly base funct7
      f3 = 3'($urandom);
      case ($urandom_range(0, 2))
         0: return mk_r(f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), dec_pkg::OPC_OP);
         1: return mk_r((f3 == 3'd1 || f3 == 3'd5) ? f7 : 7'($urandom), 5'($urandom),
                        5'($urandom), f3, 5'($urandom), dec_pkg::OPC_OP_IMM);
         default: return mk_u(20'($urandom), 5'($urandom));
      endcase
   endfunction

   function automatic void ref_decode(input logic [31:0] w, output logic [3:0] op,
                                      output logic [31:0] imm, output logic ill,
                                      output logic u1, output logic u2);
      logic [3:0] by_f3 [8];
      logic [6:0] f7;
      logic [2:0] f3;
      by_f3 = '{dec_pkg::ALU_ADD, dec_pkg::ALU_SLL, dec_pkg::ALU_SLT, dec_pkg::ALU_SLTU,
                dec_pkg::ALU_XOR, dec_pkg::ALU_SRL, dec_pkg::ALU_OR, dec_pkg::ALU_AND};
      f7  = w[31:25];
      f3  = w[14:12];
      op  = by_f3[f3];
      imm = '0;
      ill = 1'b1;
      u1  = 1'b0;
      u2  = 1'b0;
      if (w[6:0] == dec_pkg::OPC_LUI) begin
         op  = dec_pkg::ALU_LUI;
         imm = {w[31:12], 12'h000};
         ill = 1'b0;
      end else if (w[6:0] == dec_pkg::OPC_OP_IMM) begin
         imm = {{20{w[31]}}, w[31:20]};
         u1  = 1'b1;
         if (f3 == 3'd1 || f3 == 3'd5)           // shamt form
            ill = !(f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20));
         else
            ill = 1'b0;
         if (f3 == 3'd5 && f7 == 7'h20) op = dec_pkg::ALU_SRA;
      end else if (w[6:0] == dec_pkg::OPC_OP) begin
         u1 = 1'b1;
         u2 = 1'b1;
         if (f7 == 7'h00) begin
            ill = 1'b0;
         end else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) begin
            ill = 1'b0;
            op  = (f3 == 3'd0) ? dec_pkg::ALU_SUB : dec_pkg::ALU_SRA;
         end
      end
      if (ill) begin
         u1 = 1'b0;
         u2 = 1'b0;
      end
   endfunction

   // value a reader sees this cycle, writeback bypassed
   function automatic logic [31:0] reg_now(input logic [4:0] r);
      if (r == 5'd0) return '0;
      if (wb_valid && wb_rd == r) return wb_data;
      return regs[r];
   endfunction

   function automatic logic busy(input logic [4:0] r);
      return (r != 5'd0) && pend[r] && !(wb_valid && wb_rd == r);
   endfunction

   //************************************************
   // issue monitor and reference model
   //************************************************
   task automatic check_issue();
      logic [63:0] e;
      logic [31:0] w;
      logic [31:0] imm;
      logic [3:0]  op;
      logic        ill;
      logic        u1;
      logic        u2;
      if (exp_q.size() == 0) begin
         die("issue seen with no instruction outstanding");
      end else begin
         e = exp_q.pop_front();
         w = e[31:0];
         ref_decode(w, op, imm, ill, u1, u2);
         check("issue_pc", issue_pc, e[63:32]);
         check("issue_illegal", 32'(issue_illegal), 32'(ill));
         check("issue_rd", 32'(issue_rd), ill ? 32'd0 : 32'(w[11:7]));
         if (!ill && ((u1 && busy(w[19:15])) || (u2 && busy(w[24:20])) || busy(w[11:7])))
            die("instruction issued while one of its registers was still pending");
         if (!ill) begin
            check("issue_op", 32'(issue_op), 32'(op));
            check("issue_imm", issue_imm, imm);
            if (u1) check("issue_rs1_data", issue_rs1_data, reg_now(w[19:15]));
            if (u2) check("issue_rs2_data", issue_rs2_data, reg_now(w[24:20]));
         end
      end
   endtask

   always @(posedge clk) begin
      if (rst_n) begin
         check("fetch_ready", 32'(fetch_ready), 32'(held != dec_pkg::IB_DEPTH));
         if (held == 0) check("issue_valid on empty buffer", 32'(issue_valid), 32'd0);
         if (fetch_valid && fetch_ready) exp_q.push_back({fetch_pc, fetch_instr});
         if (issue_valid && issue_ready) check_issue();
         if (wb_valid && wb_rd != 5'd0) begin
            regs[wb_rd] = wb_data;
            pend[wb_rd] = 1'b0;
         end
         if (issue_valid && issue_ready && issue_rd != 5'd0) begin
            pend[issue_rd] = 1'b1;                // new issue wins over wb
            wb_q.push_back(issue_rd);
         end
         if (fetch_valid && fetch_ready) held++;
         if (issue_valid && issue_ready) held--;
      end
   end

   // writeback responder, one per issued destination
   always @(negedge clk) begin
      wb_valid = 1'b0;
      if (rst_n && wb_idx < wb_q.size()) begin
         if (force_req != force_ack) begin
            wb_valid = 1'b1;
            wb_data  = force_data;
            force_ack++;
         end else if (!wb_hold && $urandom_range(0, 2) == 0) begin
            wb_valid = 1'b1;
            wb_data  = $urandom();
         end
         if (wb_valid) begin
            wb_rd = wb_q[wb_idx];
            wb_idx++;
         end
      end
   end

   always @(negedge clk) issue_ready = bp_on ? ($urandom_range(0, 2) != 0) : 1'b1;

   //************************************************
   // drivers and tests
   //************************************************
   task automatic fetch(input logic [31:0] w);
      logic acc;
      fetch_valid = 1'b1;
      fetch_instr = w;
      fetch_pc    = pc_next;
      do begin
         acc = fetch_ready;                      // registered, steady until posedge
         @(negedge clk);
      end while (!acc);
      fetch_valid = 1'b0;
      pc_next += 32'd4;
   endtask

   task automatic wb_with(input logic [31:0] data);
      while (wb_idx >= wb_q.size()) @(negedge clk); // wait for a destination
      #1;
      force_data = data;
      force_req++;
      @(negedge clk);
   endtask

   task automatic drain();
      while (exp_q.size() != 0 || wb_idx != wb_q.size()) @(negedge clk);
   endtask

   task automatic decode_test();
      repeat (N_RAND) fetch(rand_word());
      drain();
   endtask

   task automatic operand_test();
      wb_hold = 1'b1;
      fetch(mk_u(20'hfffff, 5'd0));              // x0 dest, never written back
      for (int i = 1; i < 32; i += 6) begin
         fetch(mk_u(20'(i), 5'(i)));
         wb_with(32'hc0de_0000 ^ 32'(i * 32'h0101_0101));
         fetch(mk_r(7'h00, 5'(i), 5'(i), 3'd0, 5'd0, dec_pkg::OPC_OP)); // add x0,xi,xi
         fetch(mk_r(7'h00, 5'd0, 5'(i), 3'd6, 5'd0, dec_pkg::OPC_OP)); // or x0,xi,x0
      end
      wb_hold = 1'b0;
      drain();
   endtask

   task automatic stall_test();
      wb_hold = 1'b1;
      fetch(mk_u(20'h12345, 5'd5));
      fetch(mk_r(7'h00, 5'd3, 5'd5, 3'd0, 5'd6, dec_pkg::OPC_OP_IMM)); // addi x6,x5,3
      while (wb_idx >= wb_q.size()) @(negedge clk);
      repeat (3) @(negedge clk);
      #1;
      check("issue_valid while x5 pending", 32'(issue_valid), 32'd0);
      wb_with(32'h5a5a_0001);
      #1;
      check("wb and issue same cycle", 32'({wb_valid, issue_valid}), 32'd3);
      wb_hold = 1'b0;
      drain();
   endtask

   task automatic illegal_test();
      fetch(mk_r(7'h00, 5'd0, 5'd2, 3'd2, 5'd9, 7'b0000011));          // load
      fetch(mk_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd0, 7'b1100011));          // branch
      fetch(mk_r(7'h01, 5'd3, 5'd2, 3'd0, 5'd10, dec_pkg::OPC_OP));    // mul
      fetch(mk_r(7'h20, 5'd3, 5'd2, 3'd1, 5'd11, dec_pkg::OPC_OP_IMM)); // slli, bad upper
      fetch(mk_r(7'h01, 5'd3, 5'd2, 3'd5, 5'd12, dec_pkg::OPC_OP_IMM)); // srai, bad upper
      fetch(mk_r(7'h20, 5'd3, 5'd2, 3'd7, 5'd13, dec_pkg::OPC_OP));    // and, alt funct7
      fetch(mk_r(7'h00, 5'd4, 5'd2, 3'd0, 5'd14, dec_pkg::OPC_OP_IMM)); // legal addi
      drain();
   endtask

   task automatic backpressure_test();
      bp_on = 1'b1;
      repeat (N_RAND) fetch(rand_word());        // back to back burst
      drain();
      bp_on = 1'b0;
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      void'($urandom(32'h3593_4708));
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      decode_test();
      operand_test();
      stall_test();
      illegal_test();
      backpressure_test();
      if (exp_q.size() != 0 || wb_idx != wb_q.size() || held != 0) begin
         $display("instructions left in flight at the end of the run");
         $display("TB FAILED");
         $fatal(1, "end of run");
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- dec.f
rtl/dec_pkg.sv
rtl/dec_ib_ctl.sv
rtl/dec_decode_ctl.sv
rtl/dec_scoreboard.sv
rtl/dec_gpr_ctl.sv
rtl/dec.sv
tb/dec_properties.sv
tb/tb_dec.sv

//--- run.sh
#!/bin/sh
# compile the decode unit testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_dec -f dec.f -o sim_dec &&
./obj_dir/sim_dec ||
{ echo "simulation failed"; exit 1; }
